// ==== tb.f ====
+incdir+verilog
verilog/id_pkg.sv
verilog/id_inst_latch.sv
verilog/id_regfile.sv
verilog/id_operand_fwd.sv
verilog/id_decoder.sv
verilog/id_branch_unit.sv
verilog/id_stage.sv
test/id_stage_tb.sv

// ==== test/id_stage_tb.sv ====
`timescale 1ns/1ns
`include "id_params.svh"

module id_stage_tb;

    localparam int CLK_PERIOD = 20;
    // clock cycles for reset plus all directed tests
    localparam int TEST_CYCLES = 90;

    logic                clk;
    logic                rst;
    id_pkg::pipe_ctrl_t  pipe_ctrl_i;
    id_pkg::fetch_t      fetch_i;
    logic [`ID_XLEN-1:0] inst_rdata_i;
    id_pkg::fwd_t        ex_fwd_i;
    id_pkg::fwd_t        mem_fwd_i;
    id_pkg::fwd_t        wb_fwd_i;
    id_pkg::id_to_ex_t   id_to_ex_o;
    id_pkg::br_t         br_o;
    logic                load_stall_o;

    int          checks = 0;
    int          errors = 0;
    logic [15:0] lfsr = 16'd39811;

    id_stage u_dut (
        .clk          (clk),
        .rst          (rst),
        .pipe_ctrl_i  (pipe_ctrl_i),
        .fetch_i      (fetch_i),
        .inst_rdata_i (inst_rdata_i),
        .ex_fwd_i     (ex_fwd_i),
        .mem_fwd_i    (mem_fwd_i),
        .wb_fwd_i     (wb_fwd_i),
        .id_to_ex_o   (id_to_ex_o),
        .br_o         (br_o),
        .load_stall_o (load_stall_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * 4 * CLK_PERIOD);
        $display("timeout: tests did not complete within %0d ns", TEST_CYCLES * 4 * CLK_PERIOD);
        $display("Finished with errors");
        $finish;
    end

    // galois lfsr stepped once per bit
    task draw_word(output logic [`ID_XLEN-1:0] w);
        w = '0;
        for (int i = 0; i < `ID_XLEN; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            w = {w[`ID_XLEN-2:0], lfsr[0]};
        end
    endtask

    task compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task report_test(input string name, input int err0);
        if (errors == err0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d errors", name, errors - err0);
        end
    endtask

    function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sa,
                                          input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic id_pkg::fwd_t bus_write(input logic [4:0] addr, input logic [31:0] data);
        return '{we: 1'b1, waddr: addr, wdata: data};
    endfunction

    // bundle loads on the second edge and outputs are sampled mid-cycle after it
    task issue(input logic [31:0] pc, input logic [31:0] word);
        @(posedge clk);
        fetch_i      <= '{valid: 1'b1, pc: pc};
        inst_rdata_i <= word;
        @(posedge clk);
        @(negedge clk);
    endtask

    task clear_buses;
        @(posedge clk);
        ex_fwd_i  <= '0;
        mem_fwd_i <= '0;
        wb_fwd_i  <= '0;
    endtask

    task verify_idle;
        compare("id_to_ex_o.ctrl.rf_we", id_to_ex_o.ctrl.rf_we, 0);
        compare("id_to_ex_o.ctrl.alu_op", id_to_ex_o.ctrl.alu_op, id_pkg::ALU_NONE);
        compare("id_to_ex_o.ctrl.mem_op", id_to_ex_o.ctrl.mem_op, id_pkg::MEM_NONE);
        compare("id_to_ex_o.ctrl.br_kind", id_to_ex_o.ctrl.br_kind, id_pkg::BR_NONE);
        compare("br_o.taken", br_o.taken, 0);
        compare("load_stall_o", load_stall_o, 0);
    endtask

    task reset_state;
        int err0;
        err0 = errors;
        @(negedge clk);
        verify_idle();
        report_test("reset state", err0);
    endtask

    task forwarding_priority;
        int          err0;
        logic [31:0] v3;
        logic [31:0] v4;
        logic [31:0] vex;
        logic [31:0] vmem;
        logic [31:0] vwb;
        logic [31:0] vwb2;
        err0 = errors;
        draw_word(v3);
        draw_word(v4);
        draw_word(vex);
        draw_word(vmem);
        draw_word(vwb);
        draw_word(vwb2);
        @(posedge clk);
        wb_fwd_i <= bus_write(5'd3, v3);
        @(posedge clk);
        wb_fwd_i <= bus_write(5'd4, v4);
        @(posedge clk);
        wb_fwd_i <= '0;
        issue(32'h0040_0000, rtype(5'd3, 5'd4, 5'd5, 5'd0, 6'h21));
        compare("id_to_ex_o.rdata1", id_to_ex_o.rdata1, v3);
        compare("id_to_ex_o.rdata2", id_to_ex_o.rdata2, v4);
        compare("id_to_ex_o.ctrl.alu_op", id_to_ex_o.ctrl.alu_op, id_pkg::ALU_ADD);
        compare("id_to_ex_o.ctrl.rf_waddr", id_to_ex_o.ctrl.rf_waddr, 5);
        @(posedge clk);
        ex_fwd_i  <= bus_write(5'd3, vex);
        mem_fwd_i <= bus_write(5'd3, vmem);
        wb_fwd_i  <= bus_write(5'd3, vwb);
        @(negedge clk);
        compare("id_to_ex_o.rdata1", id_to_ex_o.rdata1, vex);
        @(posedge clk);
        ex_fwd_i <= '0;
        @(negedge clk);
        compare("id_to_ex_o.rdata1", id_to_ex_o.rdata1, vmem);
        @(posedge clk);
        mem_fwd_i <= '0;
        // new wb data that the register file does not hold yet
        wb_fwd_i  <= bus_write(5'd3, vwb2);
        @(negedge clk);
        compare("id_to_ex_o.rdata1", id_to_ex_o.rdata1, vwb2);
        // a bus naming r0 must not leak through
        @(posedge clk);
        wb_fwd_i <= bus_write(5'd0, vwb);
        issue(32'h0040_0004, rtype(5'd0, 5'd4, 5'd5, 5'd0, 6'h21));
        compare("id_to_ex_o.rdata1", id_to_ex_o.rdata1, 0);
        compare("id_to_ex_o.rdata2", id_to_ex_o.rdata2, v4);
        clear_buses();
        report_test("register read and forwarding", err0);
    endtask

    task alu_mem_decode;
        int err0;
        err0 = errors;
        issue(32'h0040_0010, itype(6'h0d, 5'd2, 5'd7, 16'h1234));
        compare("id_to_ex_o.ctrl.alu_op", id_to_ex_o.ctrl.alu_op, id_pkg::ALU_OR);
        compare("id_to_ex_o.ctrl.src2", id_to_ex_o.ctrl.src2, id_pkg::SRC2_IMM_ZEXT);
        compare("id_to_ex_o.ctrl.rf_waddr", id_to_ex_o.ctrl.rf_waddr, 7);
        compare("id_to_ex_o.ctrl.rf_we", id_to_ex_o.ctrl.rf_we, 1);
        issue(32'h0040_0014, itype(6'h23, 5'd2, 5'd8, 16'h0010));
        compare("id_to_ex_o.ctrl.mem_op", id_to_ex_o.ctrl.mem_op, id_pkg::MEM_LW);
        compare("id_to_ex_o.ctrl.rf_from_mem", id_to_ex_o.ctrl.rf_from_mem, 1);
        compare("load_stall_o", load_stall_o, 1);
        compare("id_to_ex_o.ctrl.rf_waddr", id_to_ex_o.ctrl.rf_waddr, 8);
        issue(32'h0040_0018, itype(6'h2b, 5'd2, 5'd8, 16'h0020));
        compare("id_to_ex_o.ctrl.rf_we", id_to_ex_o.ctrl.rf_we, 0);
        compare("id_to_ex_o.ctrl.mem_op", id_to_ex_o.ctrl.mem_op, id_pkg::MEM_SW);
        issue(32'h0040_001c, rtype(5'd0, 5'd4, 5'd9, 5'd3, 6'h00));
        compare("id_to_ex_o.ctrl.src1", id_to_ex_o.ctrl.src1, id_pkg::SRC1_SA);
        compare("id_to_ex_o.ctrl.alu_op", id_to_ex_o.ctrl.alu_op, id_pkg::ALU_SLL);
        // opcode 0x3f is not in the kept set
        issue(32'h0040_0020, itype(6'h3f, 5'd2, 5'd8, 16'h0020));
        verify_idle();
        report_test("alu and memory decode", err0);
    endtask

    task branch_resolve;
        int          err0;
        logic [31:0] pc;
        logic [31:0] v;
        err0 = errors;
        pc = 32'h0040_0100;
        draw_word(v);
        @(posedge clk);
        ex_fwd_i  <= bus_write(5'd3, v);
        mem_fwd_i <= bus_write(5'd4, v);
        issue(pc, itype(6'h04, 5'd3, 5'd4, 16'hfffc));
        compare("br_o.taken", br_o.taken, 1);
        // pc + 4 back by four words
        compare("br_o.target", br_o.target, 32'h0040_00f4);
        @(posedge clk);
        mem_fwd_i <= bus_write(5'd4, v ^ 32'h1);
        @(negedge clk);
        compare("br_o.taken", br_o.taken, 0);
        @(posedge clk);
        mem_fwd_i <= '0;
        ex_fwd_i  <= bus_write(5'd3, 32'd5);
        issue(pc, itype(6'h07, 5'd3, 5'd0, 16'h0008));
        compare("br_o.taken", br_o.taken, 1);
        // pc + 4 ahead by eight words
        compare("br_o.target", br_o.target, 32'h0040_0124);
        @(posedge clk);
        ex_fwd_i <= bus_write(5'd3, 32'd0);
        @(negedge clk);
        compare("br_o.taken", br_o.taken, 0);
        pc = 32'ha040_0100;
        issue(pc, {6'h02, 26'h0123456});
        compare("br_o.taken", br_o.taken, 1);
        compare("br_o.target", br_o.target, 32'ha048_d158);
        @(posedge clk);
        ex_fwd_i <= bus_write(5'd3, 32'h0040_0800);
        issue(32'h0040_0104, rtype(5'd3, 5'd0, 5'd0, 5'd0, 6'h08));
        compare("br_o.taken", br_o.taken, 1);
        compare("br_o.target", br_o.target, 32'h0040_0800);
        issue(32'h0040_0108, {6'h03, 26'h0000040});
        compare("id_to_ex_o.ctrl.rf_waddr", id_to_ex_o.ctrl.rf_waddr, `ID_LINK_REG);
        compare("id_to_ex_o.ctrl.rf_we", id_to_ex_o.ctrl.rf_we, 1);
        compare("id_to_ex_o.ctrl.src1", id_to_ex_o.ctrl.src1, id_pkg::SRC1_PC);
        compare("id_to_ex_o.ctrl.src2", id_to_ex_o.ctrl.src2, id_pkg::SRC2_EIGHT);
        compare("br_o.taken", br_o.taken, 1);
        clear_buses();
        report_test("branches", err0);
    endtask

    task stall_flush;
        int          err0;
        logic [31:0] word_a;
        logic [31:0] word_b;
        logic [31:0] word_c;
        err0 = errors;
        word_a = rtype(5'd3, 5'd4, 5'd5, 5'd0, 6'h21);
        word_b = itype(6'h0d, 5'd2, 5'd7, 16'h00ff);
        word_c = itype(6'h0e, 5'd2, 5'd9, 16'h0f0f);
        issue(32'h0040_0200, word_a);
        @(posedge clk);
        pipe_ctrl_i <= '{flush: 1'b0, stall_id: 1'b1, stall_ex: 1'b1};
        fetch_i     <= '{valid: 1'b1, pc: 32'h0040_0204};
        @(posedge clk);
        // memory moves on once the first stalled edge has passed
        inst_rdata_i <= word_b;
        @(negedge clk);
        compare("id_to_ex_o.inst", id_to_ex_o.inst, word_a);
        compare("id_to_ex_o.pc", id_to_ex_o.pc, 32'h0040_0200);
        @(posedge clk);
        @(negedge clk);
        compare("id_to_ex_o.inst", id_to_ex_o.inst, word_a);
        @(posedge clk);
        pipe_ctrl_i <= '{flush: 1'b0, stall_id: 1'b1, stall_ex: 1'b0};
        @(posedge clk);
        @(negedge clk);
        compare("id_to_ex_o.inst", id_to_ex_o.inst, 0);
        verify_idle();
        @(posedge clk);
        pipe_ctrl_i  <= '0;
        fetch_i      <= '{valid: 1'b1, pc: 32'h0040_0208};
        inst_rdata_i <= word_c;
        @(posedge clk);
        @(negedge clk);
        compare("id_to_ex_o.pc", id_to_ex_o.pc, 32'h0040_0208);
        compare("id_to_ex_o.inst", id_to_ex_o.inst, word_c);
        compare("id_to_ex_o.ctrl.alu_op", id_to_ex_o.ctrl.alu_op, id_pkg::ALU_XOR);
        // fetch stays valid so only the flush can clear the bundle
        @(posedge clk);
        pipe_ctrl_i <= '{flush: 1'b1, stall_id: 1'b0, stall_ex: 1'b0};
        @(posedge clk);
        pipe_ctrl_i <= '0;
        @(negedge clk);
        verify_idle();
        report_test("stall and flush", err0);
    endtask

    initial begin
        rst          <= 1'b1;
        pipe_ctrl_i  <= '0;
        fetch_i      <= '0;
        inst_rdata_i <= '0;
        ex_fwd_i     <= '0;
        mem_fwd_i    <= '0;
        wb_fwd_i     <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        reset_state();
        forwarding_priority();
        alu_mem_decode();
        branch_resolve();
        stall_flush();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== verilog/id_stage.sv ====
`timescale 1ns/1ns
`include "id_params.svh"

module id_stage (
    input  logic                clk,
    input  logic                rst,
    input  id_pkg::pipe_ctrl_t  pipe_ctrl_i,
    input  id_pkg::fetch_t      fetch_i,
    input  logic [`ID_XLEN-1:0] inst_rdata_i,
    input  id_pkg::fwd_t        ex_fwd_i,
    input  id_pkg::fwd_t        mem_fwd_i,
    input  id_pkg::fwd_t        wb_fwd_i,
    output id_pkg::id_to_ex_t   id_to_ex_o,
    output id_pkg::br_t         br_o,
    output logic                load_stall_o
);

    id_pkg::fetch_t      held;
    logic [`ID_XLEN-1:0] inst;
    logic [`ID_XLEN-1:0] rdata1;
    logic [`ID_XLEN-1:0] rdata2;
    id_pkg::ctrl_t       ctrl;

    id_inst_latch u_latch (
        .clk          (clk),
        .rst          (rst),
        .pipe_ctrl_i  (pipe_ctrl_i),
        .fetch_i      (fetch_i),
        .inst_rdata_i (inst_rdata_i),
        .held_o       (held),
        .inst_o       (inst)
    );

    id_decoder u_decoder (
        .valid_i      (held.valid),
        .inst_i       (inst),
        .ctrl_o       (ctrl),
        .load_stall_o (load_stall_o)
    );

    id_operand_fwd u_operand_fwd (
        .clk       (clk),
        .inst_i    (inst),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .wb_fwd_i  (wb_fwd_i),
        .rdata1_o  (rdata1),
        .rdata2_o  (rdata2)
    );

    id_branch_unit u_branch_unit (
        .pc_i      (held.pc),
        .inst_i    (inst),
        .br_kind_i (ctrl.br_kind),
        .rdata1_i  (rdata1),
        .rdata2_i  (rdata2),
        .br_o      (br_o)
    );

    assign id_to_ex_o = '{ctrl: ctrl, pc: held.pc, inst: inst, rdata1: rdata1, rdata2: rdata2};

endmodule

// ==== verilog/id_branch_unit.sv ====
`timescale 1ns/1ns
`include "id_params.svh"

module id_branch_unit (
    input  logic [`ID_XLEN-1:0] pc_i,
    input  logic [`ID_XLEN-1:0] inst_i,
    input  id_pkg::br_kind_e    br_kind_i,
    input  logic [`ID_XLEN-1:0] rdata1_i,
    input  logic [`ID_XLEN-1:0] rdata2_i,
    output id_pkg::br_t         br_o
);

    logic [`ID_XLEN-1:0] pc_plus4;
    logic [`ID_XLEN-1:0] br_target;
    logic [`ID_XLEN-1:0] jump_target;
    logic                eq;
    logic                gtz;
    logic                cond;

    assign pc_plus4    = pc_i + `ID_XLEN'(`ID_PC_STEP);
    assign br_target   = pc_plus4 + {{(`ID_XLEN-18){inst_i[15]}}, inst_i[15:0], 2'b00};
    // upper pc bits select the 256 MB region
    assign jump_target = {pc_i[`ID_XLEN-1 -: 4], inst_i[25:0], 2'b00};
    assign eq          = (rdata1_i == rdata2_i);
    assign gtz         = ($signed(rdata1_i) > 0);

    always_comb begin
        case (br_kind_i)
            id_pkg::BR_BEQ:  cond = eq;
            id_pkg::BR_BNE:  cond = !eq;
            id_pkg::BR_BGEZ: cond = !rdata1_i[`ID_XLEN-1];
            id_pkg::BR_BLTZ: cond = rdata1_i[`ID_XLEN-1];
            id_pkg::BR_BGTZ: cond = gtz;
            id_pkg::BR_BLEZ: cond = !gtz;
            default:         cond = 1'b0;
        endcase
    end

    always_comb begin
        case (br_kind_i)
            id_pkg::BR_NONE:            br_o = '0;
            id_pkg::BR_J, id_pkg::BR_JAL:   br_o = '{taken: 1'b1, target: jump_target};
            id_pkg::BR_JR, id_pkg::BR_JALR: br_o = '{taken: 1'b1, target: rdata1_i};
            default:                    br_o = '{taken: cond, target: br_target};
        endcase
    end

    // holds only while fetch hands over word-aligned pcs
    a_target_aligned: assert final (!br_o.taken || br_o.target[1:0] == 2'b00 ||
                                    br_kind_i inside {id_pkg::BR_JR, id_pkg::BR_JALR});

endmodule

// ==== verilog/id_decoder.sv ====
`timescale 1ns/1ns
`include "id_params.svh"

module id_decoder (
    input  logic                valid_i,
    input  logic [`ID_XLEN-1:0] inst_i,
    output id_pkg::ctrl_t       ctrl_o,
    output logic                load_stall_o
);

    id_pkg::opcode_e    op;
    id_pkg::funct_e     fn;
    logic [`ID_RAW-1:0] rs;
    logic [`ID_RAW-1:0] rt;
    logic [`ID_RAW-1:0] rd;
    logic [`ID_RAW-1:0] sa;
    id_pkg::ctrl_t      dec;

    function automatic id_pkg::alu_op_e funct_alu(input id_pkg::funct_e f);
        case (f)
            id_pkg::F_ADDU: return id_pkg::ALU_ADD;
            id_pkg::F_SUBU: return id_pkg::ALU_SUB;
            id_pkg::F_AND:  return id_pkg::ALU_AND;
            id_pkg::F_OR:   return id_pkg::ALU_OR;
            id_pkg::F_XOR:  return id_pkg::ALU_XOR;
            id_pkg::F_NOR:  return id_pkg::ALU_NOR;
            id_pkg::F_SLT:  return id_pkg::ALU_SLT;
            id_pkg::F_SLTU: return id_pkg::ALU_SLTU;
            id_pkg::F_SLL:  return id_pkg::ALU_SLL;
            id_pkg::F_SRL:  return id_pkg::ALU_SRL;
            id_pkg::F_SRA:  return id_pkg::ALU_SRA;
            default:        return id_pkg::ALU_NONE;
        endcase
    endfunction

    // register-writing op with the given operands and destination
    function automatic id_pkg::ctrl_t alu_ctrl(
        input id_pkg::alu_op_e    alu,
        input id_pkg::src1_e      s1,
        input id_pkg::src2_e      s2,
        input logic [`ID_RAW-1:0] dst
    );
        id_pkg::ctrl_t c;
        c          = '0;
        c.alu_op   = alu;
        c.src1     = s1;
        c.src2     = s2;
        c.rf_we    = 1'b1;
        c.rf_waddr = dst;
        return c;
    endfunction

    assign op = id_pkg::opcode_e'(inst_i[31:26]);
    assign fn = id_pkg::funct_e'(inst_i[5:0]);
    assign rs = inst_i[25:21];
    assign rt = inst_i[20:16];
    assign rd = inst_i[15:11];
    assign sa = inst_i[10:6];

    always_comb begin
        dec = '0;
        case (op)
            id_pkg::OP_SPECIAL: begin
                case (fn)
                    id_pkg::F_SLL, id_pkg::F_SRL, id_pkg::F_SRA: begin
                        if (rs == '0) begin
                            dec = alu_ctrl(funct_alu(fn), id_pkg::SRC1_SA, id_pkg::SRC2_RT, rd);
                        end
                    end
                    id_pkg::F_JR: begin
                        if (rt == '0 && rd == '0 && sa == '0) begin
                            dec.br_kind = id_pkg::BR_JR;
                        end
                    end
                    id_pkg::F_JALR: begin
                        if (rt == '0 && sa == '0) begin
                            dec = alu_ctrl(id_pkg::ALU_ADD, id_pkg::SRC1_PC, id_pkg::SRC2_EIGHT,
                                           `ID_RAW'(`ID_LINK_REG));
                            dec.br_kind = id_pkg::BR_JALR;
                        end
                    end
                    default: begin
                        if (sa == '0 && funct_alu(fn) != id_pkg::ALU_NONE) begin
                            dec = alu_ctrl(funct_alu(fn), id_pkg::SRC1_RS, id_pkg::SRC2_RT, rd);
                        end
                    end
                endcase
            end
            id_pkg::OP_REGIMM: begin
                if (rt == 5'd0) begin
                    dec.br_kind = id_pkg::BR_BLTZ;
                end else if (rt == 5'd1) begin
                    dec.br_kind = id_pkg::BR_BGEZ;
                end
            end
            id_pkg::OP_J:   dec.br_kind = id_pkg::BR_J;
            id_pkg::OP_JAL: begin
                dec = alu_ctrl(id_pkg::ALU_ADD, id_pkg::SRC1_PC, id_pkg::SRC2_EIGHT,
                               `ID_RAW'(`ID_LINK_REG));
                dec.br_kind = id_pkg::BR_JAL;
            end
            id_pkg::OP_BEQ: dec.br_kind = id_pkg::BR_BEQ;
            id_pkg::OP_BNE: dec.br_kind = id_pkg::BR_BNE;
            id_pkg::OP_BLEZ: begin
                if (rt == '0) dec.br_kind = id_pkg::BR_BLEZ;
            end
            id_pkg::OP_BGTZ: begin
                if (rt == '0) dec.br_kind = id_pkg::BR_BGTZ;
            end
            id_pkg::OP_ADDIU:
                dec = alu_ctrl(id_pkg::ALU_ADD, id_pkg::SRC1_RS, id_pkg::SRC2_IMM_SEXT, rt);
            id_pkg::OP_SLTI:
                dec = alu_ctrl(id_pkg::ALU_SLT, id_pkg::SRC1_RS, id_pkg::SRC2_IMM_SEXT, rt);
            id_pkg::OP_SLTIU:
                dec = alu_ctrl(id_pkg::ALU_SLTU, id_pkg::SRC1_RS, id_pkg::SRC2_IMM_SEXT, rt);
            id_pkg::OP_ANDI:
                dec = alu_ctrl(id_pkg::ALU_AND, id_pkg::SRC1_RS, id_pkg::SRC2_IMM_ZEXT, rt);
            id_pkg::OP_ORI:
                dec = alu_ctrl(id_pkg::ALU_OR, id_pkg::SRC1_RS, id_pkg::SRC2_IMM_ZEXT, rt);
            id_pkg::OP_XORI:
                dec = alu_ctrl(id_pkg::ALU_XOR, id_pkg::SRC1_RS, id_pkg::SRC2_IMM_ZEXT, rt);
            id_pkg::OP_LUI:
                dec = alu_ctrl(id_pkg::ALU_LUI, id_pkg::SRC1_RS, id_pkg::SRC2_IMM_SEXT, rt);
            id_pkg::OP_LB, id_pkg::OP_LBU, id_pkg::OP_LW: begin
                dec = alu_ctrl(id_pkg::ALU_ADD, id_pkg::SRC1_RS, id_pkg::SRC2_IMM_SEXT, rt);
                dec.rf_from_mem = 1'b1;
                dec.mem_op = (op == id_pkg::OP_LW) ? id_pkg::MEM_LW :
                             (op == id_pkg::OP_LB) ? id_pkg::MEM_LB : id_pkg::MEM_LBU;
            end
            id_pkg::OP_SB, id_pkg::OP_SW: begin
                dec = alu_ctrl(id_pkg::ALU_ADD, id_pkg::SRC1_RS, id_pkg::SRC2_IMM_SEXT, rt);
                dec.rf_we  = 1'b0;
                dec.mem_op = (op == id_pkg::OP_SW) ? id_pkg::MEM_SW : id_pkg::MEM_SB;
            end
            default: dec = '0;
        endcase
        // writes to r0 are dropped here, a zero word is then a true bubble
        if (dec.rf_waddr == '0) begin
            dec.rf_we = 1'b0;
        end
        if (!valid_i) begin
            dec = '0;
        end
    end

    assign ctrl_o       = dec;
    assign load_stall_o = dec.rf_from_mem;

    a_no_write_idle: assert final (valid_i || !ctrl_o.rf_we);

endmodule

// ==== verilog/id_operand_fwd.sv ====
`timescale 1ns/1ns
`include "id_params.svh"

module id_operand_fwd (
    input  logic                clk,
    input  logic [`ID_XLEN-1:0] inst_i,
    input  id_pkg::fwd_t        ex_fwd_i,
    input  id_pkg::fwd_t        mem_fwd_i,
    input  id_pkg::fwd_t        wb_fwd_i,
    output logic [`ID_XLEN-1:0] rdata1_o,
    output logic [`ID_XLEN-1:0] rdata2_o
);

    logic [`ID_RAW-1:0]  rs;
    logic [`ID_RAW-1:0]  rt;
    logic [`ID_XLEN-1:0] rf_rdata1;
    logic [`ID_XLEN-1:0] rf_rdata2;

    function automatic logic hit(input id_pkg::fwd_t f, input logic [`ID_RAW-1:0] addr);
        return f.we && (f.waddr == addr) && (f.waddr != '0);
    endfunction

    // youngest producer wins
    function automatic logic [`ID_XLEN-1:0] newest(
        input logic [`ID_RAW-1:0]  addr,
        input logic [`ID_XLEN-1:0] rf_val,
        input id_pkg::fwd_t        ex,
        input id_pkg::fwd_t        mem,
        input id_pkg::fwd_t        wb
    );
        if (hit(ex, addr)) return ex.wdata;
        if (hit(mem, addr)) return mem.wdata;
        if (hit(wb, addr)) return wb.wdata;
        return rf_val;
    endfunction

    assign rs = inst_i[25:21];
    assign rt = inst_i[20:16];

    id_regfile u_regfile (
        .clk      (clk),
        .raddr1_i (rs),
        .raddr2_i (rt),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2),
        .wr_i     (wb_fwd_i)
    );

    assign rdata1_o = newest(rs, rf_rdata1, ex_fwd_i, mem_fwd_i, wb_fwd_i);
    assign rdata2_o = newest(rt, rf_rdata2, ex_fwd_i, mem_fwd_i, wb_fwd_i);

    // decode never enables a write to r0, so execute cannot forward one
    a_ex_no_r0: assert property (@(posedge clk)
        ex_fwd_i.we |-> (ex_fwd_i.waddr != '0 || ex_fwd_i.wdata == '0));

endmodule

// ==== verilog/id_regfile.sv ====
`timescale 1ns/1ns
`include "id_params.svh"

module id_regfile (
    input  logic                clk,
    input  logic [`ID_RAW-1:0]  raddr1_i,
    input  logic [`ID_RAW-1:0]  raddr2_i,
    output logic [`ID_XLEN-1:0] rdata1_o,
    output logic [`ID_XLEN-1:0] rdata2_o,
    input  id_pkg::fwd_t        wr_i
);

    logic [`ID_XLEN-1:0] regs [`ID_NREGS];

    always_ff @(posedge clk) begin
        if (wr_i.we && wr_i.waddr != '0) begin
            regs[wr_i.waddr] <= wr_i.wdata;
        end
    end

    // r0 is hardwired, its array entry is never written
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== verilog/id_inst_latch.sv ====
`timescale 1ns/1ns
`include "id_params.svh"

module id_inst_latch (
    input  logic                clk,
    input  logic                rst,
    input  id_pkg::pipe_ctrl_t  pipe_ctrl_i,
    input  id_pkg::fetch_t      fetch_i,
    input  logic [`ID_XLEN-1:0] inst_rdata_i,
    output id_pkg::fetch_t      held_o,
    output logic [`ID_XLEN-1:0] inst_o
);

    logic                buf_valid;
    logic [`ID_XLEN-1:0] buf_inst;
    logic                capture;

    // first cycle of a double stall, memory data is about to move on
    assign capture = !rst && !pipe_ctrl_i.flush && pipe_ctrl_i.stall_id &&
                     pipe_ctrl_i.stall_ex && !buf_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            held_o    <= '0;
            buf_valid <= 1'b0;
        end else if (pipe_ctrl_i.flush) begin
            held_o <= '0;
        end else if (pipe_ctrl_i.stall_id && !pipe_ctrl_i.stall_ex) begin
            // execute moves on, so decode sends a bubble
            held_o    <= '0;
            buf_valid <= 1'b0;
        end else if (!pipe_ctrl_i.stall_id) begin
            held_o    <= fetch_i;
            buf_valid <= 1'b0;
        end else if (!buf_valid) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            buf_inst <= inst_rdata_i;
        end
    end

    assign inst_o = !held_o.valid ? '0 : (buf_valid ? buf_inst : inst_rdata_i);

    a_valid_after_rst: assert property (@(posedge clk) rst |=> !held_o.valid);

endmodule

// ==== verilog/id_pkg.sv ====
`include "id_params.svh"

package id_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
        OP_ADDIU   = 6'h09, OP_SLTI   = 6'h0a, OP_SLTIU = 6'h0b, OP_ANDI  = 6'h0c,
        OP_ORI     = 6'h0d, OP_XORI   = 6'h0e, OP_LUI   = 6'h0f, OP_LB    = 6'h20,
        OP_LW      = 6'h23, OP_LBU    = 6'h24, OP_SB    = 6'h28, OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00, F_SRL = 6'h02, F_SRA = 6'h03, F_JR   = 6'h08, F_JALR = 6'h09,
        F_ADDU = 6'h21, F_SUBU = 6'h23, F_AND = 6'h24, F_OR  = 6'h25, F_XOR  = 6'h26,
        F_NOR  = 6'h27, F_SLT = 6'h2a, F_SLTU = 6'h2b
    } funct_e;

    // zero is the inactive encoding in every control enum
    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS, SRC1_PC, SRC1_SA} src1_e;

    typedef enum logic [1:0] {SRC2_RT, SRC2_IMM_SEXT, SRC2_IMM_ZEXT, SRC2_EIGHT} src2_e;

    typedef enum logic [2:0] {MEM_NONE, MEM_LB, MEM_LBU, MEM_LW, MEM_SB, MEM_SW} mem_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BLTZ, BR_BGTZ, BR_BLEZ,
        BR_J, BR_JAL, BR_JR, BR_JALR
    } br_kind_e;

    typedef struct packed {
        logic               valid;
        logic [`ID_XLEN-1:0] pc;
    } fetch_t;

    typedef struct packed {
        logic flush;
        logic stall_id;
        logic stall_ex;
    } pipe_ctrl_t;

    typedef struct packed {
        logic               we;
        logic [`ID_RAW-1:0]  waddr;
        logic [`ID_XLEN-1:0] wdata;
    } fwd_t;

    typedef struct packed {
        alu_op_e            alu_op;
        src1_e              src1;
        src2_e              src2;
        mem_op_e            mem_op;
        logic               rf_we;
        logic [`ID_RAW-1:0]  rf_waddr;
        logic               rf_from_mem;
        br_kind_e           br_kind;
    } ctrl_t;

    typedef struct packed {
        ctrl_t              ctrl;
        logic [`ID_XLEN-1:0] pc;
        logic [`ID_XLEN-1:0] inst;
        logic [`ID_XLEN-1:0] rdata1;
        logic [`ID_XLEN-1:0] rdata2;
    } id_to_ex_t;

    typedef struct packed {
        logic               taken;
        logic [`ID_XLEN-1:0] target;
    } br_t;

endpackage

// ==== verilog/id_params.svh ====
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// data and address width
`define ID_XLEN 32

// register address width and register count
`define ID_RAW 5
`define ID_NREGS 32

// jal and jalr write the return address here
`define ID_LINK_REG 31

// byte distance between instructions
`define ID_PC_STEP 4

`endif
